/* Makefile */
VERILATOR ?= verilator
TOP ?= tx_frame_tb
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0 -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^Testbench passed$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb.f */
verilog/nic_tx_pkg.sv
verilog/tx_job_if.sv
verilog/tx_cmd_parser.sv
verilog/axi_read_requester.sv
verilog/read_stream_packer.sv
verilog/tx_frame.sv
verification/dram_model.sv
verification/tx_frame_tb.sv

/* verification/dram_model.sv */
`timescale 1ns/1ps

module dram_model (
	input logic aclk,
	input logic aresetn,

	input logic [nic_tx_pkg::ID_W-1:0] arid,
	input logic [nic_tx_pkg::ADDR_W-1:0] araddr,
	input logic [7:0] arlen,
	input logic arvalid,
	output logic arready,

	output logic [nic_tx_pkg::ID_W-1:0] rid,
	output logic [nic_tx_pkg::DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rlast,
	output logic rvalid,
	input logic rready
);

	// accepted AR requests in arrival order.
	logic [nic_tx_pkg::ADDR_W-1:0] ar_addr_log[$];
	logic [7:0] ar_len_log[$];
	// beats still owed on R.
	logic [nic_tx_pkg::ADDR_W-1:0] beat_addr_q[$];
	logic beat_last_q[$];

	// word at byte address a is {~a, a}.
	function automatic logic [nic_tx_pkg::DATA_W-1:0] mem_word(
		input logic [nic_tx_pkg::ADDR_W-1:0] a);
		return {~a, a};
	endfunction

	assign rresp = nic_tx_pkg::RESP_OKAY;

	always @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			rdata <= '0;
			rid <= '0;
		end else begin
			if (arvalid && arready) begin
				ar_addr_log.push_back(araddr);
				ar_len_log.push_back(arlen);
				rid <= arid;
				for (int i = 0; i <= int'(arlen); i++) begin
					beat_addr_q.push_back(araddr + nic_tx_pkg::ADDR_W'(4 * i));
					beat_last_q.push_back(i == int'(arlen));
				end
			end
			// random stalls on AR.
			arready <= ($urandom_range(3) != 0);
			// random gaps between beats.
			if (!rvalid || rready) begin
				if (beat_addr_q.size() != 0 && $urandom_range(3) != 0) begin
					rdata <= mem_word(beat_addr_q.pop_front());
					rlast <= beat_last_q.pop_front();
					rvalid <= 1'b1;
				end else begin
					rvalid <= 1'b0;
				end
			end
		end
	end

endmodule

/* verification/tx_frame_tb.sv */
`timescale 1ns/1ps

module tx_frame_tb;

	localparam int MAX_BURST_BEATS = 16;
	localparam int WAIT_LIMIT = 2000;

	logic aclk;
	logic aresetn;
	logic [nic_tx_pkg::DATA_W-1:0] cmd_s_tdata;
	logic cmd_s_tvalid;
	logic cmd_s_tlast;
	logic cmd_s_tready;
	logic [nic_tx_pkg::DATA_W-1:0] stat_m_tdata;
	logic stat_m_tvalid;
	logic stat_m_tlast;
	logic stat_m_tready;
	logic [nic_tx_pkg::ID_W-1:0] dram_m_arid;
	logic [nic_tx_pkg::ADDR_W-1:0] dram_m_araddr;
	logic [7:0] dram_m_arlen;
	logic [2:0] dram_m_arsize;
	logic [1:0] dram_m_arburst;
	logic dram_m_arvalid;
	logic dram_m_arready;
	logic [nic_tx_pkg::ID_W-1:0] dram_m_rid;
	logic [nic_tx_pkg::DATA_W-1:0] dram_m_rdata;
	logic [1:0] dram_m_rresp;
	logic dram_m_rlast;
	logic dram_m_rvalid;
	logic dram_m_rready;
	logic [nic_tx_pkg::DATA_W-1:0] mac_m_tdata;
	logic [3:0] mac_m_tkeep;
	logic mac_m_tvalid;
	logic mac_m_tlast;
	logic mac_m_tready;
	logic stat_done;
	int ar_checked;

	tx_frame #(.MAX_BURST_BEATS(MAX_BURST_BEATS), .READ_ID(0)) tx_frame_i (.*);

	dram_model dram_i (
		.aclk(aclk),
		.aresetn(aresetn),
		.arid(dram_m_arid),
		.araddr(dram_m_araddr),
		.arlen(dram_m_arlen),
		.arvalid(dram_m_arvalid),
		.arready(dram_m_arready),
		.rid(dram_m_rid),
		.rdata(dram_m_rdata),
		.rresp(dram_m_rresp),
		.rlast(dram_m_rlast),
		.rvalid(dram_m_rvalid),
		.rready(dram_m_rready)
	);

	always #10 aclk = ~aclk;

	task automatic abort_run();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic timed_out(input string what);
		$display("timeout while %s", what);
		abort_run();
	endtask

	task automatic check_word(input string name, input logic [nic_tx_pkg::DATA_W-1:0] exp,
		input logic [nic_tx_pkg::DATA_W-1:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_keep(input string name, input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
			abort_run();
		end
	endtask

	task automatic check_ar(input string name,
		input logic [nic_tx_pkg::ADDR_W-1:0] exp_addr, input logic [7:0] exp_len,
		input logic [nic_tx_pkg::ADDR_W-1:0] act_addr, input logic [7:0] act_len);
		if (act_addr !== exp_addr || act_len !== exp_len) begin
			$display("[FAIL] %s: expected addr %h len %0d, actual addr %h len %0d",
				name, exp_addr, exp_len, act_addr, act_len);
			abort_run();
		end
	endtask

	// inputs change 2 ns after the edge and outputs are read 1 ns later.
	task automatic next_cycle();
		@(posedge aclk);
		#2;
	endtask

	task automatic send_word(input logic [nic_tx_pkg::DATA_W-1:0] data, input logic last);
		int n;
		logic taken;
		n = 0;
		cmd_s_tdata = data;
		cmd_s_tvalid = 1'b1;
		cmd_s_tlast = last;
		do begin
			#1;
			taken = cmd_s_tready;
			next_cycle();
			n++;
			if (n > WAIT_LIMIT)
				timed_out("waiting for cmd_s_tready");
		end while (!taken);
		cmd_s_tvalid = 1'b0;
		cmd_s_tlast = 1'b0;
	endtask

	// command port must stay closed until the status word is taken.
	task automatic watch_cmd_closed(input string name);
		int n;
		n = 0;
		while (1) begin
			#1;
			if (stat_done)
				break;
			check_bit({name, " cmd_s_tready"}, 1'b0, cmd_s_tready);
			next_cycle();
			n++;
			if (n > WAIT_LIMIT)
				timed_out("waiting for the status handshake");
		end
	endtask

	task automatic recv_mac(input string name, input logic [nic_tx_pkg::ADDR_W-1:0] addr,
		input logic [nic_tx_pkg::LEN_W-1:0] len, input logic rand_ready);
		int beats;
		int got;
		int n;
		logic ready;
		logic valid;
		logic last;
		logic r_ready;
		logic [3:0] keep;
		logic [3:0] exp_keep;
		logic [nic_tx_pkg::DATA_W-1:0] data;
		logic [nic_tx_pkg::ADDR_W-1:0] a;
		beats = (int'(len) + 3) / 4;
		got = 0;
		n = 0;
		while (got < beats) begin
			ready = rand_ready ? ($urandom_range(3) != 0) : 1'b1;
			mac_m_tready = ready;
			#1;
			valid = mac_m_tvalid;
			data = mac_m_tdata;
			keep = mac_m_tkeep;
			last = mac_m_tlast;
			r_ready = dram_m_rready;
			check_bit({name, " rready"}, ready, r_ready);
			next_cycle();
			if (valid && ready) begin
				a = addr + nic_tx_pkg::ADDR_W'(4 * got);
				exp_keep = 4'b1111;
				if (got == beats - 1 && len[1:0] != 2'd0)
					exp_keep = 4'((1 << len[1:0]) - 1);
				check_word({name, " data"}, {~a, a}, data);
				check_keep({name, " keep"}, exp_keep, keep);
				check_bit({name, " tlast"}, got == beats - 1, last);
				got++;
				n = 0;
			end else begin
				n++;
				if (n > WAIT_LIMIT)
					timed_out("waiting for MAC beats");
			end
		end
		mac_m_tready = 1'b0;
	endtask

	task automatic recv_status(input string name, input logic [nic_tx_pkg::DATA_W-1:0] exp,
		input int hold);
		int n;
		n = 0;
		stat_m_tready = 1'b0;
		#1;
		while (!stat_m_tvalid) begin
			next_cycle();
			#1;
			n++;
			if (n > WAIT_LIMIT)
				timed_out("waiting for stat_m_tvalid");
		end
		check_word({name, " status"}, exp, stat_m_tdata);
		repeat (hold) begin
			next_cycle();
			#1;
			check_bit({name, " status valid held"}, 1'b1, stat_m_tvalid);
			check_word({name, " status held"}, exp, stat_m_tdata);
		end
		next_cycle();
		stat_m_tready = 1'b1;
		#1;
		check_bit({name, " status valid"}, 1'b1, stat_m_tvalid);
		check_bit({name, " status tlast"}, 1'b1, stat_m_tlast);
		next_cycle();
		stat_m_tready = 1'b0;
		stat_done = 1'b1;
	endtask

	task automatic check_bursts(input string name, input logic [nic_tx_pkg::ADDR_W-1:0] addr,
		input logic [nic_tx_pkg::LEN_W-1:0] len);
		int left;
		logic [nic_tx_pkg::ADDR_W-1:0] a;
		logic [7:0] l;
		left = (int'(len) + 3) / 4;
		a = addr;
		while (left > 0) begin
			l = 8'((left > MAX_BURST_BEATS ? MAX_BURST_BEATS : left) - 1);
			if (ar_checked >= dram_i.ar_addr_log.size()) begin
				$display("%s: an AR burst was never issued", name);
				abort_run();
			end
			check_ar({name, " AR"}, a, l, dram_i.ar_addr_log[ar_checked],
				dram_i.ar_len_log[ar_checked]);
			ar_checked++;
			a = a + nic_tx_pkg::ADDR_W'(4 * (int'(l) + 1));
			left -= int'(l) + 1;
		end
		check_word({name, " AR count"}, 32'(ar_checked), 32'(dram_i.ar_addr_log.size()));
	endtask

	task automatic run_frame(input string name, input logic [nic_tx_pkg::ADDR_W-1:0] addr,
		input logic [nic_tx_pkg::LEN_W-1:0] len, input logic rand_ready, input int hold);
		stat_done = 1'b0;
		fork
			begin
				send_word({len, addr}, 1'b0);
				send_word($urandom, 1'b0);
				send_word($urandom, 1'b1);
				watch_cmd_closed(name);
			end
			recv_mac(name, addr, len, rand_ready);
			recv_status(name, {len, addr}, hold);
		join
		check_bursts(name, addr, len);
	endtask

	task automatic test_reset_state();
		#1;
		check_bit("reset cmd_s_tready", 1'b1, cmd_s_tready);
		check_bit("reset stat_m_tvalid", 1'b0, stat_m_tvalid);
		check_bit("reset stat_m_tlast", 1'b1, stat_m_tlast);
		check_bit("reset dram_m_arvalid", 1'b0, dram_m_arvalid);
		check_bit("reset mac_m_tvalid", 1'b0, mac_m_tvalid);
		next_cycle();
	endtask

	task automatic test_multi_burst();
		run_frame("multi burst", 16'h1000, 16'd200, 1'b0, 0);
		check_word("multi burst arid", 32'd0, 32'(dram_m_arid));
		check_word("multi burst arsize", 32'd2, 32'(dram_m_arsize));
		check_word("multi burst arburst", 32'(nic_tx_pkg::BURST_INCR), 32'(dram_m_arburst));
	endtask

	task automatic test_random_frames();
		logic [nic_tx_pkg::LEN_W-1:0] len;
		logic [nic_tx_pkg::ADDR_W-1:0] addr;
		for (int i = 0; i < 20; i++) begin
			len = nic_tx_pkg::LEN_W'($urandom_range(300, 1));
			addr = nic_tx_pkg::ADDR_W'($urandom & 32'hfffc);
			run_frame($sformatf("random frame %0d", i), addr, len, 1'b1, $urandom_range(3));
		end
	endtask

	initial begin
		void'($urandom(32'hbabb_a5bb));
		aclk = 1'b0;
		aresetn = 1'b0;
		cmd_s_tdata = '0;
		cmd_s_tvalid = 1'b0;
		cmd_s_tlast = 1'b0;
		stat_m_tready = 1'b0;
		mac_m_tready = 1'b0;
		stat_done = 1'b0;
		ar_checked = 0;
		repeat (10) @(posedge aclk);
		#2;
		aresetn = 1'b1;
		test_reset_state();
		run_frame("short frame", 16'h0100, 16'd5, 1'b0, 0);
		test_multi_burst();
		run_frame("mac backpressure", 16'h2000, 16'd77, 1'b1, 0);
		run_frame("status hold", 16'h0400, 16'd9, 1'b0, 6);
		test_random_frames();
		$display("Testbench passed");
		$finish;
	end

endmodule

/* verilog/axi_read_requester.sv */
`timescale 1ns/1ps

module axi_read_requester #(
	parameter int MAX_BURST_BEATS = 16,
	parameter int READ_ID = 0
) (
	input logic aclk,
	input logic aresetn,

	tx_job_if.reader job,

	output logic [nic_tx_pkg::ID_W-1:0] arid,
	output logic [nic_tx_pkg::ADDR_W-1:0] araddr,
	output logic [7:0] arlen,
	output logic [2:0] arsize,
	output nic_tx_pkg::axi_burst_e arburst,
	output logic arvalid,
	input logic arready
);

	localparam int BEAT_W = nic_tx_pkg::LEN_W - 1;
	localparam logic [BEAT_W-1:0] MAX_BEATS = BEAT_W'(MAX_BURST_BEATS);

	nic_tx_pkg::req_state_e state;
	logic [BEAT_W-1:0] beats_left;
	logic [nic_tx_pkg::ADDR_W-1:0] next_addr;
	logic [nic_tx_pkg::LEN_W:0] bytes_up;
	logic [BEAT_W-1:0] job_beats;
	logic [BEAT_W-1:0] burst_beats;
	logic [nic_tx_pkg::ADDR_W-1:0] burst_bytes;
	logic ar_done;

	// bytes rounded up to whole words.
	assign bytes_up = {1'b0, job.bytes} + {{(nic_tx_pkg::LEN_W - 1){1'b0}}, 2'b11};
	assign job_beats = bytes_up[nic_tx_pkg::LEN_W:2];

	assign burst_beats = (beats_left > MAX_BEATS) ? MAX_BEATS : beats_left;
	assign burst_bytes = {burst_beats[nic_tx_pkg::ADDR_W-3:0], 2'b00};
	assign ar_done = arvalid && arready;

	always_ff @(posedge aclk, negedge aresetn) begin
		if (!aresetn) begin
			state <= nic_tx_pkg::REQ_IDLE;
			beats_left <= '0;
			next_addr <= '0;
		end else begin
			case (state)
				nic_tx_pkg::REQ_IDLE: begin
					if (job.start) begin
						beats_left <= job_beats;
						next_addr <= job.addr;
						state <= nic_tx_pkg::REQ_ADDR;
					end
				end
				nic_tx_pkg::REQ_ADDR: begin
					if (ar_done) begin
						beats_left <= beats_left - burst_beats;
						next_addr <= next_addr + burst_bytes;
						if (beats_left == burst_beats)
							state <= nic_tx_pkg::REQ_IDLE;
						else
							state <= nic_tx_pkg::REQ_WAIT_NEXT;
					end
				end
				// one idle cycle, then the next burst goes out.
				nic_tx_pkg::REQ_WAIT_NEXT: begin
					state <= nic_tx_pkg::REQ_ADDR;
				end
				default: begin
					state <= nic_tx_pkg::REQ_IDLE;
				end
			endcase
		end
	end

	assign arvalid = (state == nic_tx_pkg::REQ_ADDR);
	assign arid = READ_ID[nic_tx_pkg::ID_W-1:0];
	assign araddr = next_addr;
	assign arlen = 8'(burst_beats - BEAT_W'(1));
	assign arsize = 3'd2;
	assign arburst = nic_tx_pkg::BURST_INCR;

	ar_hold_a: assert property (@(posedge aclk) disable iff (!aresetn)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen));

endmodule

/* verilog/nic_tx_pkg.sv */
package nic_tx_pkg;

	localparam int ADDR_W = 16;
	localparam int LEN_W = 16;
	localparam int DATA_W = 32;
	localparam int ID_W = 4;

	// descriptor framing, one state per command word.
	typedef enum logic [2:0] {
		CMD_HEAD,
		CMD_DW2,
		CMD_DW3,
		CMD_BUSY,
		CMD_STATUS
	} parser_state_e;

	typedef enum logic [1:0] {
		REQ_IDLE,
		REQ_ADDR,
		REQ_WAIT_NEXT
	} req_state_e;

	typedef enum logic [1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR = 2'b01,
		BURST_WRAP = 2'b10
	} axi_burst_e;

	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

endpackage

/* verilog/read_stream_packer.sv */
`timescale 1ns/1ps

module read_stream_packer (
	input logic aclk,
	input logic aresetn,

	tx_job_if.sink job,

	input logic [nic_tx_pkg::DATA_W-1:0] rdata,
	input nic_tx_pkg::axi_resp_e rresp,
	input logic rlast,
	input logic rvalid,
	output logic rready,

	output logic [nic_tx_pkg::DATA_W-1:0] mac_tdata,
	output logic [3:0] mac_tkeep,
	output logic mac_tvalid,
	output logic mac_tlast,
	input logic mac_tready
);

	localparam int BEAT_W = nic_tx_pkg::LEN_W - 1;

	logic [BEAT_W-1:0] beats_left;
	logic [nic_tx_pkg::LEN_W:0] bytes_up;
	logic [3:0] tail_keep;
	logic beat_acc;
	logic last_beat;
	logic done_q;
	logic [7:0] burst_idx;
	logic [7:0] first_len;
	logic first_seen;

	assign bytes_up = {1'b0, job.bytes} + {{(nic_tx_pkg::LEN_W - 1){1'b0}}, 2'b11};
	assign beat_acc = rvalid && mac_tready;
	assign last_beat = (beats_left == BEAT_W'(1));

	always_comb begin
		case (job.bytes[1:0])
			2'd1: tail_keep = 4'b0001;
			2'd2: tail_keep = 4'b0011;
			2'd3: tail_keep = 4'b0111;
			default: tail_keep = 4'b1111;
		endcase
	end

	// straight through, the MAC paces the R channel.
	assign mac_tvalid = rvalid;
	assign rready = mac_tready;
	assign mac_tdata = rdata;
	assign mac_tlast = last_beat;
	assign mac_tkeep = last_beat ? tail_keep : 4'b1111;
	assign job.done = done_q;

	always_ff @(posedge aclk, negedge aresetn) begin
		if (!aresetn) begin
			beats_left <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= beat_acc && last_beat;
			if (job.start)
				beats_left <= bytes_up[nic_tx_pkg::LEN_W:2];
			else if (beat_acc && beats_left != '0)
				beats_left <= beats_left - BEAT_W'(1);
		end
	end

	// first burst length of the frame is the reference.
	always_ff @(posedge aclk, negedge aresetn) begin
		if (!aresetn) begin
			burst_idx <= '0;
			first_len <= '0;
			first_seen <= 1'b0;
		end else if (job.start) begin
			burst_idx <= '0;
			first_seen <= 1'b0;
		end else if (beat_acc) begin
			if (rlast) begin
				burst_idx <= '0;
				if (!first_seen) begin
					first_seen <= 1'b1;
					first_len <= burst_idx;
				end
			end else begin
				burst_idx <= burst_idx + 8'd1;
			end
		end
	end

	rresp_a: assert property (@(posedge aclk) disable iff (!aresetn)
		beat_acc |-> rresp == nic_tx_pkg::RESP_OKAY);

	rlast_a: assert property (@(posedge aclk) disable iff (!aresetn)
		beat_acc && rlast && !last_beat |-> !first_seen || burst_idx == first_len);

endmodule

/* verilog/tx_cmd_parser.sv */
`timescale 1ns/1ps

module tx_cmd_parser (
	input logic aclk,
	input logic aresetn,

	input logic [nic_tx_pkg::DATA_W-1:0] cmd_tdata,
	input logic cmd_tvalid,
	input logic cmd_tlast,
	output logic cmd_tready,

	output logic [nic_tx_pkg::DATA_W-1:0] stat_tdata,
	output logic stat_tvalid,
	output logic stat_tlast,
	input logic stat_tready,

	tx_job_if.source job
);

	nic_tx_pkg::parser_state_e state;
	logic [nic_tx_pkg::LEN_W-1:0] length;
	logic [nic_tx_pkg::ADDR_W-1:0] local_addr;
	logic cmd_beat;
	logic cmd_end;
	logic start_q;

	assign cmd_tready = (state == nic_tx_pkg::CMD_HEAD) ||
		(state == nic_tx_pkg::CMD_DW2) ||
		(state == nic_tx_pkg::CMD_DW3);
	assign cmd_beat = cmd_tvalid && cmd_tready;
	assign cmd_end = cmd_beat && cmd_tlast;

	always_ff @(posedge aclk, negedge aresetn) begin
		if (!aresetn) begin
			state <= nic_tx_pkg::CMD_HEAD;
		end else begin
			case (state)
				nic_tx_pkg::CMD_HEAD: begin
					if (cmd_end)
						state <= nic_tx_pkg::CMD_BUSY;
					else if (cmd_beat)
						state <= nic_tx_pkg::CMD_DW2;
				end
				nic_tx_pkg::CMD_DW2: begin
					if (cmd_end)
						state <= nic_tx_pkg::CMD_BUSY;
					else if (cmd_beat)
						state <= nic_tx_pkg::CMD_DW3;
				end
				// words past the third are swallowed until tlast.
				nic_tx_pkg::CMD_DW3: begin
					if (cmd_end)
						state <= nic_tx_pkg::CMD_BUSY;
				end
				nic_tx_pkg::CMD_BUSY: begin
					if (job.done)
						state <= nic_tx_pkg::CMD_STATUS;
				end
				nic_tx_pkg::CMD_STATUS: begin
					if (stat_tready)
						state <= nic_tx_pkg::CMD_HEAD;
				end
				default: begin
					state <= nic_tx_pkg::CMD_HEAD;
				end
			endcase
		end
	end

	always_ff @(posedge aclk, negedge aresetn) begin
		if (!aresetn)
			start_q <= 1'b0;
		else
			start_q <= cmd_end;
	end

	// first word is {length, address}.
	always_ff @(posedge aclk) begin
		if (cmd_beat && state == nic_tx_pkg::CMD_HEAD) begin
			length <= cmd_tdata[nic_tx_pkg::DATA_W-1 -: nic_tx_pkg::LEN_W];
			local_addr <= cmd_tdata[nic_tx_pkg::ADDR_W-1:0];
		end
	end

	assign job.addr = {local_addr[nic_tx_pkg::ADDR_W-1:2], 2'b00};
	assign job.bytes = length;
	assign job.start = start_q;

	assign stat_tdata = {length, local_addr};
	assign stat_tvalid = (state == nic_tx_pkg::CMD_STATUS);
	assign stat_tlast = 1'b1;

	zero_len_a: assert property (@(posedge aclk) disable iff (!aresetn)
		job.start |-> job.bytes != '0);

endmodule

/* verilog/tx_frame.sv */
`timescale 1ns/1ps

module tx_frame #(
	parameter int MAX_BURST_BEATS = 16,
	parameter int READ_ID = 0
) (
	input logic aclk,
	input logic aresetn,

	// word 1 is {length, address}, words 2 and 3 are ignored.
	input logic [nic_tx_pkg::DATA_W-1:0] cmd_s_tdata,
	input logic cmd_s_tvalid,
	input logic cmd_s_tlast,
	output logic cmd_s_tready,

	output logic [nic_tx_pkg::DATA_W-1:0] stat_m_tdata,
	output logic stat_m_tvalid,
	output logic stat_m_tlast,
	input logic stat_m_tready,

	output logic [nic_tx_pkg::ID_W-1:0] dram_m_arid,
	output logic [nic_tx_pkg::ADDR_W-1:0] dram_m_araddr,
	output logic [7:0] dram_m_arlen,
	output logic [2:0] dram_m_arsize,
	output logic [1:0] dram_m_arburst,
	output logic dram_m_arvalid,
	input logic dram_m_arready,

	input logic [nic_tx_pkg::ID_W-1:0] dram_m_rid,
	input logic [nic_tx_pkg::DATA_W-1:0] dram_m_rdata,
	input logic [1:0] dram_m_rresp,
	input logic dram_m_rlast,
	input logic dram_m_rvalid,
	output logic dram_m_rready,

	output logic [nic_tx_pkg::DATA_W-1:0] mac_m_tdata,
	output logic [3:0] mac_m_tkeep,
	output logic mac_m_tvalid,
	output logic mac_m_tlast,
	input logic mac_m_tready
);

	nic_tx_pkg::axi_burst_e ar_burst;
	nic_tx_pkg::axi_resp_e r_resp;

	assign dram_m_arburst = ar_burst;
	assign r_resp = nic_tx_pkg::axi_resp_e'(dram_m_rresp);

	tx_job_if job ();

	tx_cmd_parser parser_i (
		.aclk(aclk),
		.aresetn(aresetn),
		.cmd_tdata(cmd_s_tdata),
		.cmd_tvalid(cmd_s_tvalid),
		.cmd_tlast(cmd_s_tlast),
		.cmd_tready(cmd_s_tready),
		.stat_tdata(stat_m_tdata),
		.stat_tvalid(stat_m_tvalid),
		.stat_tlast(stat_m_tlast),
		.stat_tready(stat_m_tready),
		.job(job.source)
	);

	axi_read_requester #(
		.MAX_BURST_BEATS(MAX_BURST_BEATS),
		.READ_ID(READ_ID)
	) requester_i (
		.aclk(aclk),
		.aresetn(aresetn),
		.job(job.reader),
		.arid(dram_m_arid),
		.araddr(dram_m_araddr),
		.arlen(dram_m_arlen),
		.arsize(dram_m_arsize),
		.arburst(ar_burst),
		.arvalid(dram_m_arvalid),
		.arready(dram_m_arready)
	);

	read_stream_packer packer_i (
		.aclk(aclk),
		.aresetn(aresetn),
		.job(job.sink),
		.rdata(dram_m_rdata),
		.rresp(r_resp),
		.rlast(dram_m_rlast),
		.rvalid(dram_m_rvalid),
		.rready(dram_m_rready),
		.mac_tdata(mac_m_tdata),
		.mac_tkeep(mac_m_tkeep),
		.mac_tvalid(mac_m_tvalid),
		.mac_tlast(mac_m_tlast),
		.mac_tready(mac_m_tready)
	);

	// only our own read ID may come back.
	rid_a: assert property (@(posedge aclk) disable iff (!aresetn)
		dram_m_rvalid |-> dram_m_rid == READ_ID[nic_tx_pkg::ID_W-1:0]);

endmodule

/* verilog/tx_job_if.sv */
`timescale 1ns/1ps

interface tx_job_if;

	// address and byte count hold from start until done.
	logic [nic_tx_pkg::ADDR_W-1:0] addr;
	logic [nic_tx_pkg::LEN_W-1:0] bytes;
	logic start;
	logic done;

	modport source (
		output addr,
		output bytes,
		output start,
		input done
	);

	modport reader (
		input addr,
		input bytes,
		input start
	);

	modport sink (
		input bytes,
		input start,
		output done
	);

endinterface
